// ==== project.f ====
+incdir+rtl
rtl/execPkg.sv
rtl/resultIf.sv
rtl/mathUnit.sv
rtl/ldStUnit.sv
rtl/ringBuff.sv
rtl/wbSelect.sv
rtl/execUnit.sv
verif/execUnitTb.sv

// ==== verif/execTests.txt ====
// kind opType opClass opCode dst src1 src2 src3 expDst expData
// kind 0 math, 1 load, 2 store, 3 move; load data is (src1+src2) ^ 5A5A0000
0 0 0 0 01 00000005 00000007 00000000 01 0000000C
0 0 0 1 02 00000003 00000005 00000000 02 FFFFFFFE
0 0 1 0 03 00010001 00010001 00000000 03 00020001
0 0 1 1 04 00000010 00000020 00000005 04 00000205
0 0 0 0 05 FFFFFFFF 00000002 00000000 05 00000001
0 0 1 0 06 12345678 00000010 00000000 06 23456780
1 3 0 0 07 00001000 00000020 00000000 07 5A5A1020
1 3 1 0 08 00002000 00000004 00000000 08 5A5A2004
2 3 2 0 00 00003000 00000008 CAFEF00D 00 00000000
2 3 3 0 00 00004000 0000000C 12345678 00 00000000
3 0 3 1 09 DEADBEEF 00000000 00000000 09 DEADBEEF
3 0 3 1 0A 0BADC0DE 00000000 00000000 0A 0BADC0DE
1 3 0 0 0B 10000000 00000100 00000000 0B 4A5A0100
0 0 1 1 0C 00000003 00000004 FFFFFFF0 0C FFFFFFFC
3 0 3 1 0D 01234567 00000000 00000000 0D 01234567
1 3 1 0 0E 00000FF0 00000010 00000000 0E 5A5A1000
0 0 0 1 0F 00000100 00000001 00000000 0F 000000FF
3 0 3 1 10 AAAA5555 00000000 00000000 10 AAAA5555
3 0 3 1 11 00000042 00000000 00000000 11 00000042
1 3 0 0 12 00000001 FFFFFFFF 00000000 12 5A5A0000
2 3 3 0 00 00000010 00000020 0000BEEF 00 00000000
0 0 0 0 13 7FFFFFFF 00000001 00000000 13 80000000
0 0 1 0 14 FFFFFFFF FFFFFFFF 00000000 14 00000001
3 0 3 1 15 5A5A5A5A 00000000 00000000 15 5A5A5A5A
0 0 1 1 16 00000002 80000000 00000001 16 00000001

// ==== verif/execUnitTb.sv ====
////////////////////////////////////////
// Execution lane testbench
// File-driven commands and memory responders
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "execParams.svh"

module execUnitTb;

	localparam int DEPTH      = `EXEC_MATH_DEPTH;
	localparam int FIELDS     = 10;                  // Words per test line
	localparam int MAX_LINES  = 64;
	localparam int KIND_MATH  = 0;
	localparam int KIND_LOAD  = 1;
	localparam int KIND_STORE = 2;
	localparam int KIND_MOVE  = 3;

	logic              clock;
	logic              rst;
	logic              issueValid;
	execPkg::cmdT      cmd;
	execPkg::dataT     src1;
	execPkg::dataT     src2;
	execPkg::dataT     src3;
	execPkg::issueNoT  curIssueNo;
	logic [1:0]        memGrant;
	logic [1:0]        memEnd;
	execPkg::dataT     memRdData [2];

	wire [1:0]         memReq;
	wire [1:0]         memWrite;
	wire [1:0]         ldStDone;
	wire [1:0]         ldStall;
	wire execPkg::dataT     memAddrEvn;
	wire execPkg::dataT     memAddrOdd;
	wire execPkg::dataT     memStDataEvn;
	wire execPkg::dataT     memStDataOdd;
	wire               wbValid;
	wire execPkg::dstT      wbDst;
	wire execPkg::issueNoT  wbIssueNo;
	wire execPkg::dataT     wbData;
	wire               mathDone;
	wire               moveStall;

	logic [31:0]       vec [0:MAX_LINES*FIELDS-1];
	int                numLines;
	int                cycle = 0;
	int                limit = 0;
	int                pending = 0;
	int                seed = 32'h3db3_9c73;
	int                seedEvn;
	int                seedOdd;

	// Expected write-backs by issue number
	bit                expValid [256];
	bit                expUsed  [256];
	bit                expMath  [256];
	execPkg::wbTokenT  expTok   [256];
	execPkg::dataT     expData  [256];
	int                issueCycle [256];
	execPkg::issueNoT  mathQ [$];                   // Math issues in result order

	// Current access per memory port
	bit                expWrite [2];
	execPkg::dataT     expAddr  [2];
	execPkg::dataT     expSt    [2];
	bit                busy     [2];
	int                accessCnt [2];
	int                doneCnt   [2];

	execUnit DUT (
		.clock(clock), .rst(rst), .issueValid(issueValid), .cmd(cmd),
		.src1(src1), .src2(src2), .src3(src3), .curIssueNo(curIssueNo),
		.memReqEvn(memReq[0]), .memWriteEvn(memWrite[0]), .memAddrEvn(memAddrEvn),
		.memStDataEvn(memStDataEvn), .memGrantEvn(memGrant[0]), .memEndEvn(memEnd[0]),
		.memRdDataEvn(memRdData[0]), .ldStDoneEvn(ldStDone[0]), .ldStallEvn(ldStall[0]),
		.memReqOdd(memReq[1]), .memWriteOdd(memWrite[1]), .memAddrOdd(memAddrOdd),
		.memStDataOdd(memStDataOdd), .memGrantOdd(memGrant[1]), .memEndOdd(memEnd[1]),
		.memRdDataOdd(memRdData[1]), .ldStDoneOdd(ldStDone[1]), .ldStallOdd(ldStall[1]),
		.wbValid(wbValid), .wbDst(wbDst), .wbIssueNo(wbIssueNo), .wbData(wbData),
		.mathDone(mathDone), .moveStall(moveStall)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;                     // 20 ns period
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkData(input execPkg::dataT got, input execPkg::dataT exp,
	                         input string name);
		if (got !== exp) begin
			abortRun($sformatf("ERROR: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkToken(input execPkg::wbTokenT got, input execPkg::wbTokenT exp,
	                          input string name);
		if ((got.dst !== exp.dst) || (got.issueNo !== exp.issueNo)) begin
			abortRun($sformatf("ERROR: %s got dst %h issueNo %h expected dst %h issueNo %h",
			                   name, got.dst, got.issueNo, exp.dst, exp.issueNo));
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			abortRun($sformatf("ERROR: %s got %h expected %h", name, got, exp));
		end
	endtask

	function automatic string portName(input string base, input int p);
		return {base, (p != 0) ? "Odd" : "Evn"};
	endfunction

	function automatic int drawDelay(input int p, input int span);
		int r;
		if (p == 0) begin
			r = $random(seedEvn);
		end else begin
			r = $random(seedOdd);
		end
		return {r} % span;
	endfunction

	task automatic checkIdle();
		checkBit(wbValid, 1'b0, "wbValid");
		checkBit(mathDone, 1'b0, "mathDone");
		checkBit(moveStall, 1'b0, "moveStall");
		for (int p = 0; p < 2; p++) begin
			checkBit(memReq[p], 1'b0, portName("memReq", p));
			checkBit(memWrite[p], 1'b0, portName("memWrite", p));
			checkBit(ldStDone[p], 1'b0, portName("ldStDone", p));
			checkBit(ldStall[p], 1'b0, portName("ldStall", p));
		end
	endtask

	////////////////////////////////////////
	// Write-back and port monitor
	////////////////////////////////////////
	task automatic checkWriteBack(input execPkg::issueNoT n, input logic due);
		execPkg::wbTokenT  got;
		got = '{valid: wbValid, dst: wbDst, issueNo: wbIssueNo};
		if (!expValid[n] || expUsed[n]) begin
			abortRun($sformatf("Write-back for issue %h has no matching expected entry", n));
		end
		if (expMath[n] != due) begin
			abortRun($sformatf("Math result for issue %h came at cycle %0d instead of %0d",
			                   n, cycle, issueCycle[n] + DEPTH));
		end
		checkToken(got, expTok[n], "wbToken");
		checkData(wbData, expData[n], "wbData");
		checkBit(mathDone, due, "mathDone");
		expUsed[n] = 1'b1;
		pending--;
	endtask

	always @(negedge clock) begin
		if (!rst) begin
			if ((mathQ.size() != 0) && (cycle == issueCycle[mathQ[0]] + DEPTH)) begin
				checkBit(wbValid, 1'b1, "wbValid");                     // Math result due now
				checkWriteBack(mathQ.pop_front(), 1'b1);
			end else if (wbValid) begin
				checkWriteBack(wbIssueNo, 1'b0);
			end else begin
				checkBit(mathDone, 1'b0, "mathDone");
			end
			for (int p = 0; p < 2; p++) begin
				if (memReq[p] || busy[p]) begin
					checkBit(ldStall[p], 1'b1, portName("ldStall", p));   // Access outstanding
				end
				if (ldStDone[p]) begin
					doneCnt[p]++;
					checkBit(ldStall[p], !expWrite[p], portName("ldStall", p));
				end
			end
		end
	end

	// Cycle count and run limit
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if ((limit > 0) && (cycle >= limit)) begin
			abortRun($sformatf("Timeout after %0d cycles with %0d write-backs missing",
			                   cycle, pending));
		end
	end

	////////////////////////////////////////
	// Memory responder
	////////////////////////////////////////
	task automatic serveMem(input int p);
		int             grantDly;
		int             endDly;
		execPkg::dataT  addr;
		forever begin
			@(negedge clock);
			if (!rst && memReq[p]) begin
				addr = (p != 0) ? memAddrOdd : memAddrEvn;
				checkBit(memWrite[p], expWrite[p], portName("memWrite", p));
				checkData(addr, expAddr[p], portName("memAddr", p));
				if (expWrite[p]) begin
					checkData((p != 0) ? memStDataOdd : memStDataEvn, expSt[p],
					          portName("memStData", p));
				end
				grantDly = drawDelay(p, 4);
				endDly   = 1 + drawDelay(p, 4);
				repeat (grantDly + 1) @(posedge clock);
				#2;
				memGrant[p] = 1'b1;
				busy[p]     = 1'b1;
				@(posedge clock);
				#2;
				memGrant[p] = 1'b0;
				repeat (endDly - 1) begin
					@(posedge clock);
					#2;
				end
				memEnd[p]    = 1'b1;
				memRdData[p] = addr ^ 32'h5A5A_0000;    // Load data rule
				@(posedge clock);
				#2;
				memEnd[p] = 1'b0;
				busy[p]   = 1'b0;
			end
		end
	endtask

	initial serveMem(0);
	initial serveMem(1);

	////////////////////////////////////////
	// Command issue
	////////////////////////////////////////
	task automatic issueLine(input int idx);
		int                base;
		int                kind;
		int                port;
		execPkg::issueNoT  num;
		base = idx * FIELDS;
		kind = vec[base];
		port = vec[base + 2][0];
		num  = execPkg::issueNoT'(idx + 1);
		// Hold back while the target is busy
		while (((kind == KIND_LOAD || kind == KIND_STORE) && (ldStall[port] || ldStDone[port]))
		       || ((kind == KIND_MOVE) && moveStall)) begin
			issueValid = 1'b0;
			@(posedge clock);
			#2;
		end
		cmd.opType  = execPkg::opTypeT'(vec[base + 1][1:0]);
		cmd.opClass = vec[base + 2][1:0];
		cmd.opCode  = vec[base + 3][1:0];
		cmd.dst     = execPkg::dstT'(vec[base + 4]);
		cmd.issueNo = num;
		src1        = vec[base + 5];
		src2        = vec[base + 6];
		src3        = vec[base + 7];
		curIssueNo  = num;
		issueValid  = 1'b1;
		if (kind != KIND_STORE) begin
			expValid[num]   = 1'b1;
			expMath[num]    = (kind == KIND_MATH);
			expTok[num]     = '{valid: 1'b1, dst: execPkg::dstT'(vec[base + 8]), issueNo: num};
			expData[num]    = vec[base + 9];
			issueCycle[num] = cycle;
			pending++;
		end
		if (kind == KIND_MATH) begin
			mathQ.push_back(num);
		end
		if (kind == KIND_LOAD || kind == KIND_STORE) begin
			expWrite[port] = (kind == KIND_STORE);
			expAddr[port]  = vec[base + 5] + vec[base + 6];
			expSt[port]    = vec[base + 7];
			accessCnt[port]++;
		end
		@(posedge clock);
		#2;
	endtask

	initial begin
		int missing;
		rst         = 1'b1;
		issueValid  = 1'b0;
		cmd         = '0;
		src1        = '0;
		src2        = '0;
		src3        = '0;
		curIssueNo  = '0;
		memGrant    = '0;
		memEnd      = '0;
		memRdData[0] = '0;
		memRdData[1] = '0;
		seedEvn     = seed;
		seedOdd     = seed + 1;
		$readmemh("verif/execTests.txt", vec);
		numLines = 0;
		while ((numLines < MAX_LINES) && !$isunknown(vec[numLines * FIELDS])) begin
			numLines++;
		end
		if (numLines == 0) begin
			abortRun("Test vector file is missing or holds no lines");
		end
		limit = numLines * 16 + 100;

		repeat (15) begin
			@(negedge clock);
			checkIdle();
		end
		@(posedge clock);
		#2;
		rst = 1'b0;                                     // 16 cycles of reset
		@(negedge clock);
		checkIdle();
		@(posedge clock);
		#2;

		for (int i = 0; i < numLines; i++) begin
			issueLine(i);
		end
		issueValid = 1'b0;

		// Drain results and outstanding accesses
		while ((pending != 0) || (ldStall != 2'b00)) begin
			@(negedge clock);
		end
		@(posedge clock);
		for (int p = 0; p < 2; p++) begin
			if (doneCnt[p] != accessCnt[p]) begin
				abortRun($sformatf("%s pulsed %0d times for %0d accesses",
				                   portName("ldStDone", p), doneCnt[p], accessCnt[p]));
			end
		end
		missing = 0;
		for (int n = 0; n < 256; n++) begin
			if (expValid[n] && !expUsed[n]) begin
				missing++;
			end
		end
		if (missing != 0) begin
			abortRun($sformatf("%0d expected write-backs never appeared", missing));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/execUnit.sv ====
////////////////////////////////////////
// Vector execution lane
// Routes commands and merges write-backs
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "execParams.svh"

module execUnit (
	input  wire                    clock,
	input  wire                    rst,
	input  wire                    issueValid,
	input  wire execPkg::cmdT      cmd,
	input  wire execPkg::dataT     src1,
	input  wire execPkg::dataT     src2,
	input  wire execPkg::dataT     src3,
	input  wire execPkg::issueNoT  curIssueNo,
	output logic                   memReqEvn,
	output logic                   memWriteEvn,
	output execPkg::dataT          memAddrEvn,
	output execPkg::dataT          memStDataEvn,
	input  wire                    memGrantEvn,
	input  wire                    memEndEvn,
	input  wire execPkg::dataT     memRdDataEvn,
	output logic                   ldStDoneEvn,
	output logic                   ldStallEvn,
	output logic                   memReqOdd,
	output logic                   memWriteOdd,
	output execPkg::dataT          memAddrOdd,
	output execPkg::dataT          memStDataOdd,
	input  wire                    memGrantOdd,
	input  wire                    memEndOdd,
	input  wire execPkg::dataT     memRdDataOdd,
	output logic                   ldStDoneOdd,
	output logic                   ldStallOdd,
	output logic                   wbValid,
	output execPkg::dstT           wbDst,
	output execPkg::issueNoT       wbIssueNo,
	output execPkg::dataT          wbData,
	output logic                   mathDone,
	output logic                   moveStall
);

	logic              isMath;
	logic              isMem;
	logic              mathReq;
	logic              moveReq;
	logic              evnReq;
	logic              oddReq;

	logic              mvWe;
	execPkg::wbTokenT  mvTokIn;
	execPkg::dataT     mvDataIn;
	logic              mvEmpty;

	resultIf mathRes ();
	resultIf evnRes ();
	resultIf oddRes ();
	resultIf moveRes ();

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////
	assign isMath  = issueValid & (cmd.opType == execPkg::MATH);
	assign isMem   = issueValid & (cmd.opType == execPkg::MEM);
	assign mathReq = isMath & ((cmd.opClass == execPkg::CLS_ARITH) |
	                           (cmd.opClass == execPkg::CLS_MULT));
	assign moveReq = isMath & (cmd.opClass == execPkg::CLS_MOVE) &
	                 (cmd.opCode == execPkg::MOVE_SRC1);
	assign evnReq  = isMem & ~cmd.opClass[0];
	assign oddReq  = isMem &  cmd.opClass[0];

	// Move enters the buffers one cycle after issue
	always_ff @(posedge clock) begin
		if (rst) begin
			mvWe <= 1'b0;
		end else begin
			mvWe <= moveReq;
		end
	end

	always_ff @(posedge clock) begin
		mvTokIn  <= '{valid: 1'b1, dst: cmd.dst, issueNo: cmd.issueNo};
		mvDataIn <= src1;
	end

	////////////////////////////////////////
	// Execution blocks
	////////////////////////////////////////
	mathUnit #(.DEPTH(`EXEC_MATH_DEPTH)) uMath (
		.clock(clock), .rst(rst), .req(mathReq), .cmd(cmd),
		.src1(src1), .src2(src2), .src3(src3), .res(mathRes)
	);

	ldStUnit uLdStEvn (
		.clock(clock), .rst(rst), .req(evnReq), .cmd(cmd),
		.src1(src1), .src2(src2), .src3(src3),
		.memGrant(memGrantEvn), .memEnd(memEndEvn), .memRdData(memRdDataEvn),
		.memReq(memReqEvn), .memWrite(memWriteEvn), .memAddr(memAddrEvn),
		.memStData(memStDataEvn), .done(ldStDoneEvn), .stall(ldStallEvn),
		.res(evnRes)
	);

	ldStUnit uLdStOdd (
		.clock(clock), .rst(rst), .req(oddReq), .cmd(cmd),
		.src1(src1), .src2(src2), .src3(src3),
		.memGrant(memGrantOdd), .memEnd(memEndOdd), .memRdData(memRdDataOdd),
		.memReq(memReqOdd), .memWrite(memWriteOdd), .memAddr(memAddrOdd),
		.memStData(memStDataOdd), .done(ldStDoneOdd), .stall(ldStallOdd),
		.res(oddRes)
	);

	// Token and data buffers share strobes and stay aligned
	ringBuff #(.TYPE(execPkg::wbTokenT), .NUM_ENTRY(`EXEC_MOVE_ENTRIES)) uMoveTok (
		.clock(clock), .rst(rst), .we(mvWe), .re(moveRes.take),
		.wrData(mvTokIn), .rdData(moveRes.token), .full(moveStall), .empty(mvEmpty)
	);

	ringBuff #(.TYPE(execPkg::dataT), .NUM_ENTRY(`EXEC_MOVE_ENTRIES)) uMoveData (
		.clock(clock), .rst(rst), .we(mvWe), .re(moveRes.take),
		.wrData(mvDataIn), .rdData(moveRes.data), .full(), .empty()
	);

	assign moveRes.valid = ~mvEmpty;

	////////////////////////////////////////
	// Write-back merge
	////////////////////////////////////////
	wbSelect uWbSel (
		.curIssueNo(curIssueNo),
		.math(mathRes), .ldEvn(evnRes), .ldOdd(oddRes), .move(moveRes),
		.wbValid(wbValid), .wbDst(wbDst), .wbIssueNo(wbIssueNo),
		.wbData(wbData), .mathDone(mathDone)
	);

endmodule

`default_nettype wire

// ==== rtl/wbSelect.sv ====
////////////////////////////////////////
// Write-back selector
// Math first, then oldest waiting result
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module wbSelect (
	input  wire execPkg::issueNoT  curIssueNo,
	resultIf.sink                  math,
	resultIf.sink                  ldEvn,
	resultIf.sink                  ldOdd,
	resultIf.sink                  move,
	output logic                   wbValid,
	output execPkg::dstT           wbDst,
	output execPkg::issueNoT       wbIssueNo,
	output execPkg::dataT          wbData,
	output logic                   mathDone
);

	typedef enum logic [2:0] {
		SEL_NONE, SEL_MATH, SEL_EVN, SEL_ODD, SEL_MOVE
	} selT;

	selT               sel;
	execPkg::issueNoT  ageEvn;
	execPkg::issueNoT  ageOdd;
	execPkg::issueNoT  ageMove;
	execPkg::issueNoT  bestAge;
	execPkg::wbTokenT  winTok;
	execPkg::dataT     winData;

	// Age wraps modulo the issue number width
	assign ageEvn  = curIssueNo - ldEvn.token.issueNo;
	assign ageOdd  = curIssueNo - ldOdd.token.issueNo;
	assign ageMove = curIssueNo - move.token.issueNo;

	////////////////////////////////////////
	// Winner selection
	////////////////////////////////////////
	always_comb begin
		sel     = SEL_NONE;
		bestAge = '0;
		if (math.valid) begin
			sel = SEL_MATH;                             // Cannot wait
		end else begin
			if (ldEvn.valid) begin
				sel     = SEL_EVN;
				bestAge = ageEvn;
			end
			if (ldOdd.valid && ((sel == SEL_NONE) || (ageOdd > bestAge))) begin
				sel     = SEL_ODD;
				bestAge = ageOdd;
			end
			if (move.valid && ((sel == SEL_NONE) || (ageMove > bestAge))) begin
				sel = SEL_MOVE;
			end
		end
	end

	always_comb begin
		winTok  = math.token;
		winData = math.data;
		case (sel)
			SEL_EVN: begin
				winTok  = ldEvn.token;
				winData = ldEvn.data;
			end
			SEL_ODD: begin
				winTok  = ldOdd.token;
				winData = ldOdd.data;
			end
			SEL_MOVE: begin
				winTok  = move.token;
				winData = move.data;
			end
			default: ;
		endcase
	end

	assign math.take  = (sel == SEL_MATH);
	assign ldEvn.take = (sel == SEL_EVN);
	assign ldOdd.take = (sel == SEL_ODD);
	assign move.take  = (sel == SEL_MOVE);

	assign wbValid   = (sel != SEL_NONE);
	assign wbDst     = winTok.dst;
	assign wbIssueNo = winTok.issueNo;
	assign wbData    = winData;
	assign mathDone  = math.valid;

endmodule

`default_nettype wire

// ==== rtl/ringBuff.sv ====
////////////////////////////////////////
// Circular buffer of any payload type
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "execParams.svh"

module ringBuff #(
	parameter type TYPE      = execPkg::dataT,
	parameter int  NUM_ENTRY = `EXEC_MOVE_ENTRIES
)(
	input  wire      clock,
	input  wire      rst,
	input  wire      we,
	input  wire      re,
	input  var TYPE  wrData,
	output TYPE      rdData,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1;
	localparam int CNT_W = $clog2(NUM_ENTRY + 1);

	TYPE               mem [NUM_ENTRY];
	logic [PTR_W-1:0]  wrPtr;
	logic [PTR_W-1:0]  rdPtr;
	logic [CNT_W-1:0]  count;
	logic              doWr;
	logic              doRd;

	assign doWr  = we & ~full;                          // Writes to a full buffer are lost
	assign doRd  = re & ~empty;
	assign full  = (count == CNT_W'(NUM_ENTRY));
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWr) begin
				wrPtr <= (wrPtr == PTR_W'(NUM_ENTRY - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRd) begin
				rdPtr <= (rdPtr == PTR_W'(NUM_ENTRY - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doWr, doRd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doWr) begin
			mem[wrPtr] <= wrData;
		end
	end

	assign rdData = mem[rdPtr];                         // Head entry

endmodule

`default_nettype wire

// ==== rtl/ldStUnit.sv ====
////////////////////////////////////////
// Load/store port
// One memory access at a time with a held load result
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ldStUnit (
	input  wire                 clock,
	input  wire                 rst,
	input  wire                 req,
	input  wire execPkg::cmdT   cmd,
	input  wire execPkg::dataT  src1,
	input  wire execPkg::dataT  src2,
	input  wire execPkg::dataT  src3,
	input  wire                 memGrant,
	input  wire                 memEnd,
	input  wire execPkg::dataT  memRdData,
	output logic                memReq,
	output logic                memWrite,
	output execPkg::dataT       memAddr,
	output execPkg::dataT       memStData,
	output logic                done,
	output logic                stall,
	resultIf.source             res
);

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		REQUEST = 2'b01,
		ACCESS  = 2'b10
	} stateT;

	stateT             state;
	logic              isStore;
	logic              accEnd;
	logic              holdValid;
	execPkg::wbTokenT  curTok;
	execPkg::wbTokenT  holdTok;
	execPkg::dataT     holdData;

	assign accEnd = (state == ACCESS) & memEnd;

	////////////////////////////////////////
	// Access controller
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= IDLE;
			done      <= 1'b0;
			holdValid <= 1'b0;
		end else begin
			done <= accEnd;                             // Pulse after memEnd
			case (state)
				IDLE:    if (req) state <= REQUEST;
				REQUEST: if (memGrant) state <= ACCESS;
				ACCESS:  if (memEnd) state <= IDLE;
				default: state <= IDLE;
			endcase
			if (res.take) begin
				holdValid <= 1'b0;
			end
			if (accEnd && !isStore) begin
				holdValid <= 1'b1;
			end
		end
	end

	// Command capture and load result
	always_ff @(posedge clock) begin
		if ((state == IDLE) && req) begin
			memAddr   <= src1 + src2;
			memStData <= src3;
			isStore   <= cmd.opClass[1];
			curTok    <= '{valid: 1'b1, dst: cmd.dst, issueNo: cmd.issueNo};
		end
		if (accEnd && !isStore) begin
			holdData <= memRdData;
			holdTok  <= curTok;
		end
	end

	assign memReq   = (state == REQUEST);
	assign memWrite = (state != IDLE) & isStore;        // Direction for whole access
	assign stall    = req | (state != IDLE) | holdValid;

	assign res.valid = holdValid;
	assign res.token = '{valid: holdValid, dst: holdTok.dst, issueNo: holdTok.issueNo};
	assign res.data  = holdData;

endmodule

`default_nettype wire

// ==== rtl/mathUnit.sv ====
////////////////////////////////////////
// Integer multiply-add pipeline
// add, sub, mul, fma with a travelling token
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "execParams.svh"

module mathUnit #(
	parameter int DEPTH = `EXEC_MATH_DEPTH
)(
	input  wire                 clock,
	input  wire                 rst,
	input  wire                 req,
	input  wire execPkg::cmdT   cmd,
	input  wire execPkg::dataT  src1,
	input  wire execPkg::dataT  src2,
	input  wire execPkg::dataT  src3,
	resultIf.source             res
);

	execPkg::dataT     product;
	execPkg::dataT     result;
	execPkg::wbTokenT  newTok;

	execPkg::dataT     dataPipe [DEPTH];
	execPkg::wbTokenT  tokPipe  [DEPTH];

	////////////////////////////////////////
	// First stage arithmetic
	////////////////////////////////////////
	assign product = src1 * src2;                   // Keeps the low word and wraps

	always_comb begin
		case (cmd.opClass)
			execPkg::CLS_ARITH: begin
				if (cmd.opCode == execPkg::ARITH_SUB) begin
					result = src1 - src2;
				end else begin
					result = src1 + src2;
				end
			end
			execPkg::CLS_MULT: begin
				if (cmd.opCode == execPkg::MULT_FMA) begin
					result = product + src3;
				end else begin
					result = product;
				end
			end
			default: result = src1;
		endcase
	end

	assign newTok = '{valid: req, dst: cmd.dst, issueNo: cmd.issueNo};

	////////////////////////////////////////
	// Shift pipeline
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		dataPipe[0] <= result;
		tokPipe[0]  <= newTok;
		for (int i = 1; i < DEPTH; i++) begin
			dataPipe[i] <= dataPipe[i-1];
			tokPipe[i]  <= tokPipe[i-1];
		end
		// Clear the in-flight valid bits
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				tokPipe[i].valid <= 1'b0;
			end
		end
	end

	// Last stage is offered for one cycle only
	assign res.valid = tokPipe[DEPTH-1].valid;
	assign res.token = tokPipe[DEPTH-1];
	assign res.data  = dataPipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== rtl/resultIf.sv ====
////////////////////////////////////////
// Write-back candidate link
// One source offering a result to the selector
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface resultIf;

	logic              valid;                       // Candidate present
	execPkg::wbTokenT  token;                       // Destination and age
	execPkg::dataT     data;                        // Result word
	logic              take;                        // Selector picked this one

	// Producer side
	modport source (
		output valid,
		output token,
		output data,
		input  take
	);

	// Selector side
	modport sink (
		input  valid,
		input  token,
		input  data,
		output take
	);

endinterface

`default_nettype wire

// ==== rtl/execPkg.sv ====
////////////////////////////////////////
// Execution lane shared types
// Command, write-back token and opcodes
////////////////////////////////////////
`default_nettype none
`include "execParams.svh"

package execPkg;

	typedef logic [`EXEC_DATA_W-1:0]  dataT;       // Operand or result
	typedef logic [`EXEC_ISSUE_W-1:0] issueNoT;    // Issue sequence number
	typedef logic [`EXEC_DST_W-1:0]   dstT;        // Destination index

	////////////////////////////////////////
	// Opcode fields
	////////////////////////////////////////
	typedef enum logic [1:0] {
		MATH = 2'b00,                                // Math and moves
		MEM  = 2'b11                                 // Load/store
	} opTypeT;

	typedef enum logic [1:0] {
		CLS_ARITH = 2'b00,
		CLS_MULT  = 2'b01,
		CLS_MOVE  = 2'b11
	} mathClassT;

	typedef enum logic [1:0] {ARITH_ADD = 2'b00, ARITH_SUB = 2'b01} arithCodeT;
	typedef enum logic [1:0] {MULT_MUL = 2'b00, MULT_FMA = 2'b01} multCodeT;
	typedef enum logic [1:0] {MOVE_SRC1 = 2'b01} moveCodeT;

	////////////////////////////////////////
	// Command and write-back token
	////////////////////////////////////////
	typedef struct packed {
		opTypeT      opType;
		logic [1:0]  opClass;                       // For memory bit 1 is store and bit 0 odd port
		logic [1:0]  opCode;
		dstT         dst;
		issueNoT     issueNo;
	} cmdT;

	typedef struct packed {
		logic        valid;
		dstT         dst;
		issueNoT     issueNo;
	} wbTokenT;

endpackage

`default_nettype wire

// ==== rtl/execParams.svh ====
////////////////////////////////////////
// Execution lane widths and sizes
////////////////////////////////////////
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Operand and result word
`define EXEC_DATA_W        32

// Issue sequence number that wraps
`define EXEC_ISSUE_W       8

// Destination register index
`define EXEC_DST_W         5

`define EXEC_MATH_DEPTH    4      // Math pipeline stages
`define EXEC_MOVE_ENTRIES  8      // Move buffer slots

`endif
